//--- boardman_interface.f
hdl/bm_line_pkg.sv
hdl/bm_cmd_pkg.sv
hdl/bm_stream_if.sv
hdl/bm_uart.sv
hdl/bm_cobs_decode.sv
hdl/bm_cobs_encode.sv
hdl/bm_cmd_engine.sv
hdl/boardman_interface.sv
tb/boardman_interface_checker.sv
tb/boardman_interface_tb.sv

//--- Bender.yml
package:
  name: boardman_interface

sources:
  - hdl/bm_line_pkg.sv
  - hdl/bm_cmd_pkg.sv
  - hdl/bm_stream_if.sv
  - hdl/bm_uart.sv
  - hdl/bm_cobs_decode.sv
  - hdl/bm_cobs_encode.sv
  - hdl/bm_cmd_engine.sv
  - hdl/boardman_interface.sv
  - target: test
    files:
      - tb/boardman_interface_checker.sv
      - tb/boardman_interface_tb.sv

//--- tb/boardman_interface_tb.sv
`timescale 1ns/1ps

module boardman_interface_tb;
    localparam int BIT_CLKS = 32;
    localparam int N_WRITES = 8;
    localparam int N_READS = 8;
    // all commands, the bad frames and the aborted one
    localparam int N_FRAMES = 1 + N_WRITES + N_READS + 9;
    // 16 bytes each way at 10 bits a byte, doubled for slack
    localparam int FRAME_CLKS = 2 * 16 * 10 * BIT_CLKS * 2;

    typedef struct packed {
        logic wr;
        bm_cmd_pkg::strb_t strb;
        bm_cmd_pkg::word_adr_t adr;
        bm_cmd_pkg::data_t dat;
    } bus_op_t;

    logic clk = 1'b0;
    logic reset_i;
    logic bm_rx_i;
    logic bm_tx_o;
    bm_cmd_pkg::word_adr_t adr_o;
    bm_cmd_pkg::data_t dat_o;
    bm_cmd_pkg::data_t dat_i;
    logic en_o;
    logic wr_o;
    bm_cmd_pkg::strb_t wstrb_o;
    logic ack_i;

    logic [15:0] lfsr = 16'd97;
    bm_cmd_pkg::data_t mem [1024];
    bus_op_t bus_q [$];
    bm_line_pkg::byte_t cmd_q [$];
    bm_line_pkg::byte_t exp_q [$];
    bm_line_pkg::byte_t got_q [$];
    bm_line_pkg::byte_t raw_q [$];
    int rx_frames = 0;
    int frames_expected = 0;
    string test_name = "";

    boardman_interface uut (
        .clk(clk), .reset_i(reset_i), .bm_rx_i(bm_rx_i), .bm_tx_o(bm_tx_o),
        .adr_o(adr_o), .dat_o(dat_o), .dat_i(dat_i),
        .en_o(en_o), .wr_o(wr_o), .wstrb_o(wstrb_o), .ack_i(ack_i)
    );

    always #4 clk = ~clk;

    // 16-bit Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "run stopped at the first error");
    endtask

    // start bit, 8 data bits LSB first, stop bit
    task automatic send_byte(input bm_line_pkg::byte_t b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            bm_rx_i = bits[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
    endtask

    task automatic send_raw();
        foreach (cmd_q[i]) begin
            send_byte(cmd_q[i]);
        end
    endtask

    // each COBS block is its length + 1 followed by its non-zero bytes
    task automatic send_frame();
        bm_line_pkg::byte_t blk [$];
        for (int i = 0; i <= cmd_q.size(); i++) begin
            if (i == cmd_q.size() || cmd_q[i] == 8'h00) begin
                send_byte(8'(blk.size() + 1));
                foreach (blk[j]) begin
                    send_byte(blk[j]);
                end
                blk.delete();
            end else begin
                blk.push_back(cmd_q[i]);
            end
        end
        send_byte(8'h00);
    endtask

    task automatic check_reply(input string name);
        frames_expected++;
        wait (rx_frames == frames_expected);
        assert (got_q.size() == exp_q.size()) else
            report_error($sformatf("Mismatch %s: expected %0d reply bytes, actual %0d",
                                   name, exp_q.size(), got_q.size()));
        foreach (exp_q[i]) begin
            assert (got_q[i] == exp_q[i]) else
                report_error($sformatf("Mismatch %s: expected byte %0d = %h, actual %h",
                                       name, i, exp_q[i], got_q[i]));
        end
        assert (bus_q.size() == 0) else
            report_error($sformatf("%s left %0d bus transfers undone", name, bus_q.size()));
        @(negedge clk);
    endtask

    task automatic write_command(input string name, input logic [11:0] a, input int n);
        bm_cmd_pkg::cmd_addr_t cmd;
        bus_op_t op;
        logic [13:0] b;
        logic bit22;
        bm_line_pkg::byte_t d;
        test_name = name;
        bit22 = rand_bits(1);
        cmd = {1'b1, bit22, 10'd0, a};
        cmd_q = {cmd[23:16], cmd[15:8], cmd[7:0]};
        op = '0;
        // lane and word follow the running byte address
        for (int k = 0; k < n; k++) begin
            b = a + k;
            d = rand_bits(8);
            cmd_q.push_back(d);
            op.wr = 1'b1;
            op.adr = bm_cmd_pkg::word_adr_t'(b >> 2);
            op.strb[b[1:0]] = 1'b1;
            op.dat[b[1:0] * 8 +: 8] = d;
            if (b[1:0] == 2'd3 || k == n - 1) begin
                bus_q.push_back(op);
                op = '0;
            end
        end
        exp_q = {cmd[23:16], cmd[15:8], cmd[7:0], 8'(n)};
        send_frame();
        check_reply(name);
    endtask

    task automatic read_command(input string name, input logic [11:0] a, input int len);
        bm_cmd_pkg::cmd_addr_t cmd;
        bus_op_t op;
        logic [13:0] b;
        logic bit22;
        test_name = name;
        bit22 = rand_bits(1);
        cmd = {1'b0, bit22, 10'd0, a};
        cmd_q = {cmd[23:16], cmd[15:8], cmd[7:0], 8'(len)};
        exp_q = {cmd[23:16], cmd[15:8], cmd[7:0]};
        for (int k = 0; k <= len; k++) begin
            b = a + k;
            if (k == 0 || b[1:0] == 2'd0) begin
                op = '0;
                op.adr = bm_cmd_pkg::word_adr_t'(b >> 2);
                bus_q.push_back(op);
            end
            exp_q.push_back(mem[b[11:2]][b[1:0] * 8 +: 8]);
        end
        send_frame();
        check_reply(name);
    endtask

    // memory model with a random ack delay of 0 to 3 cycles
    initial begin : bus_responder
        bus_op_t op;
        int delay;
        bm_cmd_pkg::data_t mask;
        forever begin
            @(negedge clk);
            if (en_o === 1'b1) begin
                delay = rand_bits(2);
                repeat (delay) @(negedge clk);
                assert (bus_q.size() > 0) else
                    report_error("bus transfer seen where no command asks for one");
                op = bus_q.pop_front();
                assert (adr_o == op.adr && wr_o == op.wr && wstrb_o == op.strb) else
                    report_error($sformatf({"Mismatch %s bus: expected adr %h wr %b strb %b, ",
                                            "actual adr %h wr %b strb %b"}, test_name, op.adr,
                                           op.wr, op.strb, adr_o, wr_o, wstrb_o));
                if (op.wr) begin
                    mask = {{8{op.strb[3]}}, {8{op.strb[2]}}, {8{op.strb[1]}}, {8{op.strb[0]}}};
                    assert ((dat_o & mask) == (op.dat & mask)) else
                        report_error($sformatf("Mismatch %s write data: expected %h, actual %h",
                                               test_name, op.dat & mask, dat_o & mask));
                    mem[adr_o[9:0]] = (mem[adr_o[9:0]] & ~mask) | (dat_o & mask);
                end else begin
                    dat_i = mem[adr_o[9:0]];
                end
                ack_i = 1'b1;
                @(negedge clk);
                ack_i = 1'b0;
            end
        end
    end

    // receives bm_tx_o and COBS-decodes each reply into got_q
    initial begin : tx_monitor
        bm_line_pkg::byte_t b;
        int k;
        int code;
        forever begin
            @(negedge clk);
            if (bm_tx_o === 1'b0) begin
                repeat (BIT_CLKS / 2) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CLKS) @(negedge clk);
                    b[i] = bm_tx_o;
                end
                repeat (BIT_CLKS) @(negedge clk);
                assert (bm_tx_o === 1'b1) else
                    report_error("reply byte ends without a stop bit");
                if (b != 8'h00) begin
                    raw_q.push_back(b);
                end else begin
                    got_q.delete();
                    k = 0;
                    while (k < raw_q.size()) begin
                        code = raw_q[k];
                        k++;
                        for (int j = 1; j < code; j++) begin
                            got_q.push_back(raw_q[k]);
                            k++;
                        end
                        if (code < 255 && k < raw_q.size())
                            got_q.push_back(8'h00);
                    end
                    raw_q.delete();
                    rx_frames++;
                end
            end
        end
    end

    always @(uut.u_checker.fail_count) begin
        assert (uut.u_checker.fail_count == 0) else
            report_error("a bus protocol assertion in the checker failed");
    end

    initial begin : watchdog
        #(N_FRAMES * FRAME_CLKS * 8);
        $display("Timeout: the commands did not complete in the expected time");
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        logic [11:0] a;
        reset_i = 1'b1;
        bm_rx_i = 1'b1;
        dat_i = '0;
        ack_i = 1'b0;
        for (int i = 0; i < 1024; i++)
            mem[i] = 32'(i) * 32'h9e37_79b1 + 32'h1357_2468;
        repeat (8) @(negedge clk);
        reset_i = 1'b0;
        repeat (4) @(negedge clk);

        a = rand_bits(12);
        write_command("aligned write", {a[11:2], 2'b00}, 4);
        repeat (N_WRITES) write_command("write", rand_bits(12), 1 + rand_bits(4) % 9);
        repeat (N_READS)
            read_command("read", rand_bits(12), rand_bits(4) % (bm_cmd_pkg::MAX_READ_LEN + 1));

        // bad frames get no reply and no bus transfer
        cmd_q = {8'(rand_bits(8)), 8'(rand_bits(8))};
        send_frame();
        read_command("read after short frame", rand_bits(12), 3);
        cmd_q = {8'h00, 8'h01, 8'h04, 8'(bm_cmd_pkg::MAX_READ_LEN + 1 + rand_bits(7))};
        send_frame();
        read_command("read after long read", rand_bits(12), bm_cmd_pkg::MAX_READ_LEN);
        cmd_q = {8'h06, 8'h01, 8'h02, 8'h05, 8'h03, 8'h00};
        send_raw();
        read_command("read after bad code", rand_bits(12), 0);

        // write cut off by a run of null bytes
        cmd_q = {8'h08, 8'h81, 8'h12, 8'h34, 8'h56, 8'h00, 8'h00, 8'h00, 8'h00};
        send_raw();
        a = rand_bits(12);
        write_command("write after null run", a, 6);
        read_command("read after null run", a, 5);

        repeat (4 * BIT_CLKS) @(negedge clk);
        if (rx_frames == frames_expected) begin
            $display("Finished with no errors");
        end else begin
            $display("an extra reply arrived after the last command");
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- tb/boardman_interface_checker.sv
`timescale 1ns/1ps

module boardman_interface_checker (
    input logic                  clk,
    input logic                  reset_i,
    input logic                  bus_en_i,
    input logic                  bus_wr_i,
    input bm_cmd_pkg::word_adr_t bus_adr_i,
    input bm_cmd_pkg::strb_t     bus_wstrb_i,
    input logic                  bus_ack_i
);
    // failed assertions so far
    int fail_count = 0;

    // a transfer holds its address until ack
    held_until_ack: assert property (@(posedge clk) disable iff (reset_i)
        bus_en_i && !bus_ack_i |=> bus_en_i && $stable(bus_adr_i))
    else begin
        $error("bus transfer dropped or address moved before ack");
        fail_count++;
    end

    wr_needs_en: assert property (@(posedge clk) disable iff (reset_i)
        bus_wr_i |-> bus_en_i)
    else begin
        $error("wr_o high without en_o");
        fail_count++;
    end

    wr_has_strobe: assert property (@(posedge clk) disable iff (reset_i)
        bus_wr_i |-> bus_wstrb_i != '0)
    else begin
        $error("bus write with no byte strobe set");
        fail_count++;
    end

    idle_after_reset: assert property (@(posedge clk) reset_i |=> !bus_en_i)
    else begin
        $error("en_o high in the cycle after reset");
        fail_count++;
    end

endmodule

bind boardman_interface boardman_interface_checker u_checker (
    .clk(clk),
    .reset_i(reset_i),
    .bus_en_i(en_o),
    .bus_wr_i(wr_o),
    .bus_adr_i(adr_o),
    .bus_wstrb_i(wstrb_o),
    .bus_ack_i(ack_i)
);

//--- hdl/boardman_interface.sv
`timescale 1ns/1ps

module boardman_interface (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  bm_rx_i,
    output logic                  bm_tx_o,
    output bm_cmd_pkg::word_adr_t adr_o,
    output bm_cmd_pkg::data_t     dat_o,
    input  bm_cmd_pkg::data_t     dat_i,
    output logic                  en_o,
    output logic                  wr_o,
    output bm_cmd_pkg::strb_t     wstrb_o,
    input  logic                  ack_i
);
    bm_line_pkg::byte_t rx_byte;
    logic rx_byte_valid;
    bm_line_pkg::byte_t tx_byte;
    logic tx_byte_valid;
    logic tx_busy;
    logic resync;

    bm_stream_if rx_frame ();
    bm_stream_if tx_frame ();

    bm_uart u_uart (
        .clk(clk), .reset_i(reset_i), .rx_i(bm_rx_i), .tx_o(bm_tx_o),
        .rx_byte_o(rx_byte), .rx_byte_valid_o(rx_byte_valid),
        .tx_byte_i(tx_byte), .tx_byte_valid_i(tx_byte_valid), .tx_busy_o(tx_busy)
    );

    bm_cobs_decode u_decode (
        .clk(clk), .reset_i(reset_i), .rx_byte_i(rx_byte), .rx_byte_valid_i(rx_byte_valid),
        .frame_o(rx_frame.source), .resync_o(resync)
    );

    bm_cmd_engine u_engine (
        .clk(clk), .reset_i(reset_i), .resync_i(resync),
        .rx_frame(rx_frame.sink), .tx_frame(tx_frame.source),
        .adr_o(adr_o), .dat_o(dat_o), .dat_i(dat_i),
        .en_o(en_o), .wr_o(wr_o), .wstrb_o(wstrb_o), .ack_i(ack_i)
    );

    bm_cobs_encode u_encode (
        .clk(clk), .reset_i(reset_i), .resync_i(resync), .frame_i(tx_frame.sink),
        .tx_byte_o(tx_byte), .tx_byte_valid_o(tx_byte_valid), .tx_busy_i(tx_busy)
    );

endmodule

//--- hdl/bm_cmd_engine.sv
`timescale 1ns/1ps

module bm_cmd_engine (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  resync_i,
    bm_stream_if.sink             rx_frame,
    bm_stream_if.source           tx_frame,
    output bm_cmd_pkg::word_adr_t adr_o,
    output bm_cmd_pkg::data_t     dat_o,
    input  bm_cmd_pkg::data_t     dat_i,
    output logic                  en_o,
    output logic                  wr_o,
    output bm_cmd_pkg::strb_t     wstrb_o,
    input  logic                  ack_i
);
    bm_cmd_pkg::cmd_state_t state;
    bm_cmd_pkg::cmd_addr_t addr;
    bm_cmd_pkg::word_adr_t word_adr;
    // write data going out, or the last word read
    bm_cmd_pkg::data_t data;
    bm_cmd_pkg::strb_t strb;
    // bytes written, or read bytes still to send minus one
    bm_cmd_pkg::len_t len;
    logic [1:0] lane;
    logic write_last;
    logic rx_take;
    logic tx_take;

    assign rx_frame.ready = state inside {bm_cmd_pkg::st_addr2, bm_cmd_pkg::st_addr1,
                                          bm_cmd_pkg::st_addr0, bm_cmd_pkg::st_read_len,
                                          bm_cmd_pkg::st_write_byte, bm_cmd_pkg::st_drain};
    assign tx_frame.valid = state inside {bm_cmd_pkg::st_echo2, bm_cmd_pkg::st_echo1,
                                          bm_cmd_pkg::st_echo0, bm_cmd_pkg::st_read_send,
                                          bm_cmd_pkg::st_write_count};
    assign tx_frame.last = (state == bm_cmd_pkg::st_read_send && len == '0)
                         || state == bm_cmd_pkg::st_write_count;
    assign tx_frame.err = 1'b0;
    assign rx_take = rx_frame.valid && rx_frame.ready;
    assign tx_take = tx_frame.valid && tx_frame.ready;

    // address echo is big-endian
    always_comb begin
        case (state)
            bm_cmd_pkg::st_echo2:     tx_frame.data = addr[23:16];
            bm_cmd_pkg::st_echo1:     tx_frame.data = addr[15:8];
            bm_cmd_pkg::st_echo0:     tx_frame.data = addr[7:0];
            bm_cmd_pkg::st_read_send: tx_frame.data = data[{lane, 3'b000} +: 8];
            default:                  tx_frame.data = len;
        endcase
    end

    assign adr_o = word_adr;
    assign dat_o = data;
    assign en_o = (state == bm_cmd_pkg::st_read_bus) || (state == bm_cmd_pkg::st_write_bus);
    assign wr_o = (state == bm_cmd_pkg::st_write_bus);
    assign wstrb_o = strb;

    always_ff @(posedge clk) begin
        if (reset_i || resync_i) begin
            state <= bm_cmd_pkg::st_idle;
            strb <= '0;
        end else begin
            case (state)
                bm_cmd_pkg::st_idle: begin
                    strb <= '0;
                    if (rx_frame.valid)
                        state <= bm_cmd_pkg::st_addr2;
                end
                bm_cmd_pkg::st_addr2: if (rx_take) begin
                    addr[23:16] <= rx_frame.data;
                    state <= rx_frame.last ? bm_cmd_pkg::st_idle : bm_cmd_pkg::st_addr1;
                end
                bm_cmd_pkg::st_addr1: if (rx_take) begin
                    addr[15:8] <= rx_frame.data;
                    state <= rx_frame.last ? bm_cmd_pkg::st_idle : bm_cmd_pkg::st_addr0;
                end
                bm_cmd_pkg::st_addr0: if (rx_take) begin
                    addr[7:0] <= rx_frame.data;
                    // bit 22 plays no part in the bus address
                    word_adr <= {addr[21:8], rx_frame.data[7:2]};
                    lane <= rx_frame.data[1:0];
                    len <= '0;
                    if (rx_frame.last)
                        state <= bm_cmd_pkg::st_idle;
                    else if (addr[23])
                        state <= bm_cmd_pkg::st_write_byte;
                    else
                        state <= bm_cmd_pkg::st_read_len;
                end
                bm_cmd_pkg::st_read_len: if (rx_take) begin
                    len <= rx_frame.data;
                    if (!rx_frame.last)
                        state <= bm_cmd_pkg::st_drain;
                    else if (rx_frame.err
                             || rx_frame.data > bm_cmd_pkg::len_t'(bm_cmd_pkg::MAX_READ_LEN))
                        state <= bm_cmd_pkg::st_idle;
                    else
                        state <= bm_cmd_pkg::st_echo2;
                end
                bm_cmd_pkg::st_write_byte: if (rx_take) begin
                    data[{lane, 3'b000} +: 8] <= rx_frame.data;
                    strb[lane] <= 1'b1;
                    lane <= lane + 1'b1;
                    len <= len + 1'b1;
                    write_last <= rx_frame.last;
                    if (rx_frame.err)
                        state <= bm_cmd_pkg::st_idle;
                    else if (rx_frame.last || lane == 2'd3)
                        state <= bm_cmd_pkg::st_write_bus;
                end
                bm_cmd_pkg::st_write_bus: if (ack_i) begin
                    strb <= '0;
                    word_adr <= word_adr + 1'b1;
                    state <= write_last ? bm_cmd_pkg::st_echo2 : bm_cmd_pkg::st_write_byte;
                end
                bm_cmd_pkg::st_echo2: if (tx_take)
                    state <= bm_cmd_pkg::st_echo1;
                bm_cmd_pkg::st_echo1: if (tx_take)
                    state <= bm_cmd_pkg::st_echo0;
                bm_cmd_pkg::st_echo0: if (tx_take)
                    state <= addr[23] ? bm_cmd_pkg::st_write_count : bm_cmd_pkg::st_read_bus;
                bm_cmd_pkg::st_read_bus: if (ack_i) begin
                    data <= dat_i;
                    state <= bm_cmd_pkg::st_read_send;
                end
                bm_cmd_pkg::st_read_send: if (tx_take) begin
                    len <= len - 1'b1;
                    lane <= lane + 1'b1;
                    if (len == '0) begin
                        state <= bm_cmd_pkg::st_idle;
                    end else if (lane == 2'd3) begin
                        word_adr <= word_adr + 1'b1;
                        state <= bm_cmd_pkg::st_read_bus;
                    end
                end
                bm_cmd_pkg::st_write_count: if (tx_take)
                    state <= bm_cmd_pkg::st_idle;
                bm_cmd_pkg::st_drain: if (rx_take && rx_frame.last)
                    state <= bm_cmd_pkg::st_idle;
                default: state <= bm_cmd_pkg::st_idle;
            endcase
        end
    end

endmodule

//--- hdl/bm_cobs_encode.sv
`timescale 1ns/1ps

module bm_cobs_encode (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               resync_i,
    bm_stream_if.sink          frame_i,
    output bm_line_pkg::byte_t tx_byte_o,
    output logic               tx_byte_valid_o,
    input  logic               tx_busy_i
);
    typedef enum logic [1:0] {
        enc_collect,
        enc_code,
        enc_data,
        enc_delim
    } enc_state_t;

    enc_state_t state;
    bm_line_pkg::byte_t blk_buf [bm_cmd_pkg::ENC_DEPTH];
    logic [$clog2(bm_cmd_pkg::ENC_DEPTH):0] cnt;
    logic [$clog2(bm_cmd_pkg::ENC_DEPTH):0] idx;
    logic final_blk;
    logic extra_blk;
    logic block_done;

    assign frame_i.ready = (state == enc_collect);
    // the UART raises busy the cycle after a byte is taken
    assign tx_byte_valid_o = (state != enc_collect) && !tx_busy_i;
    assign block_done = tx_byte_valid_o
                      && ((state == enc_code && cnt == '0)
                          || (state == enc_data && idx == cnt - 1'b1));

    always_comb begin
        case (state)
            enc_code: tx_byte_o = bm_line_pkg::byte_t'(cnt) + 8'd1;
            enc_data: tx_byte_o = blk_buf[idx[$clog2(bm_cmd_pkg::ENC_DEPTH)-1:0]];
            default:  tx_byte_o = 8'h00;
        endcase
    end

    // non-zero bytes of the open block
    always_ff @(posedge clk) begin
        if (frame_i.valid && frame_i.ready && frame_i.data != 8'h00)
            blk_buf[cnt[$clog2(bm_cmd_pkg::ENC_DEPTH)-1:0]] <= frame_i.data;
    end

    always_ff @(posedge clk) begin
        if (reset_i || resync_i) begin
            state <= enc_collect;
            cnt <= '0;
            final_blk <= 1'b0;
            extra_blk <= 1'b0;
        end else begin
            case (state)
                enc_collect: if (frame_i.valid) begin
                    if (frame_i.data != 8'h00)
                        cnt <= cnt + 1'b1;
                    if (frame_i.data == 8'h00 || frame_i.last)
                        state <= enc_code;
                    final_blk <= frame_i.last;
                    // a trailing zero leaves an empty block behind it
                    extra_blk <= frame_i.last && frame_i.data == 8'h00;
                end
                enc_code: if (tx_byte_valid_o) begin
                    idx <= '0;
                    state <= enc_data;
                end
                enc_data: if (tx_byte_valid_o)
                    idx <= idx + 1'b1;
                enc_delim: if (tx_byte_valid_o)
                    state <= enc_collect;
                default: state <= enc_collect;
            endcase
            if (block_done) begin
                cnt <= '0;
                if (extra_blk) begin
                    extra_blk <= 1'b0;
                    state <= enc_code;
                end else if (final_blk) begin
                    state <= enc_delim;
                end else begin
                    state <= enc_collect;
                end
            end
        end
    end

endmodule

//--- hdl/bm_cobs_decode.sv
`timescale 1ns/1ps

module bm_cobs_decode (
    input  logic               clk,
    input  logic               reset_i,
    input  bm_line_pkg::byte_t rx_byte_i,
    input  logic               rx_byte_valid_i,
    bm_stream_if.source        frame_o,
    output logic               resync_o
);
    bm_line_pkg::byte_t rem;
    logic code_max;
    logic in_frame;
    logic pend_valid;
    bm_line_pkg::byte_t pend_data;
    logic out_valid;
    bm_line_pkg::byte_t out_data;
    logic out_last;
    logic out_err;
    logic frame_err;
    logic out_full;
    logic [$clog2(bm_cmd_pkg::NULL_RUN)-1:0] null_cnt;

    assign frame_o.valid = out_valid;
    assign frame_o.data = out_data;
    assign frame_o.last = out_last;
    assign frame_o.err = out_err;
    // holding register would be overwritten by a push now
    assign out_full = out_valid && !frame_o.ready;

    // one decoded byte is kept pending until the next raw byte says whether it is last
    always_ff @(posedge clk) begin
        resync_o <= 1'b0;
        if (frame_o.valid && frame_o.ready)
            out_valid <= 1'b0;
        if (reset_i) begin
            out_valid <= 1'b0;
            in_frame <= 1'b0;
            pend_valid <= 1'b0;
            frame_err <= 1'b0;
            null_cnt <= '0;
        end else if (rx_byte_valid_i && rx_byte_i == 8'h00) begin
            null_cnt <= null_cnt + 1'b1;
            in_frame <= 1'b0;
            pend_valid <= 1'b0;
            frame_err <= 1'b0;
            if (null_cnt == bm_cmd_pkg::NULL_RUN - 1) begin
                resync_o <= 1'b1;
                out_valid <= 1'b0;
                null_cnt <= '0;
            end else if (pend_valid) begin
                out_valid <= 1'b1;
                out_data <= pend_data;
                out_last <= 1'b1;
                // frame closed before its block was complete
                out_err <= frame_err || out_full || rem != 8'd0;
            end
        end else if (rx_byte_valid_i) begin
            null_cnt <= '0;
            if (!in_frame || rem == 8'd0) begin
                in_frame <= 1'b1;
                rem <= rx_byte_i - 1'b1;
                code_max <= (rx_byte_i == 8'hff);
            end else begin
                rem <= rem - 1'b1;
            end
            // a code byte after a short block stands for a zero
            if (in_frame && (rem != 8'd0 || !code_max)) begin
                pend_valid <= 1'b1;
                pend_data <= (rem == 8'd0) ? 8'h00 : rx_byte_i;
                if (pend_valid) begin
                    out_valid <= 1'b1;
                    out_data <= pend_data;
                    out_last <= 1'b0;
                    out_err <= 1'b0;
                    if (out_full)
                        frame_err <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/bm_uart.sv
`timescale 1ns/1ps

module bm_uart (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               rx_i,
    output logic               tx_o,
    output bm_line_pkg::byte_t rx_byte_o,
    output logic               rx_byte_valid_o,
    input  bm_line_pkg::byte_t tx_byte_i,
    input  logic               tx_byte_valid_i,
    output logic               tx_busy_o
);
    logic [bm_line_pkg::ACC_BITS:0] acc;
    logic en_16x;
    logic [1:0] rx_sync;
    logic rx_busy;
    logic [3:0] rx_tick;
    logic [3:0] rx_bit;
    bm_line_pkg::byte_t rx_shift;
    logic [9:0] tx_shift;
    logic [3:0] tx_tick;
    logic [3:0] tx_bit;

    // carry out of the accumulator is the 16x enable
    always_ff @(posedge clk) begin
        if (reset_i)
            acc <= '0;
        else
            acc <= {1'b0, acc[bm_line_pkg::ACC_BITS-1:0]}
                 + (bm_line_pkg::ACC_BITS + 1)'(bm_line_pkg::ACC_INC);
    end
    assign en_16x = acc[bm_line_pkg::ACC_BITS];

    assign rx_byte_o = rx_shift;

    // bit 0 is the start bit, 1..8 data LSB first, 9 the stop bit
    always_ff @(posedge clk) begin
        rx_sync <= {rx_sync[0], rx_i};
        rx_byte_valid_o <= 1'b0;
        if (reset_i) begin
            rx_sync <= 2'b11;
            rx_busy <= 1'b0;
            rx_tick <= '0;
            rx_bit <= '0;
        end else if (!rx_busy) begin
            if (en_16x && !rx_sync[1]) begin
                rx_busy <= 1'b1;
                rx_tick <= '0;
                rx_bit <= '0;
            end
        end else if (en_16x) begin
            rx_tick <= rx_tick + 1'b1;
            // middle of the bit
            if (rx_tick == 4'd7) begin
                rx_bit <= rx_bit + 1'b1;
                if (rx_bit == 4'd0 && rx_sync[1]) begin
                    rx_busy <= 1'b0;
                end else if (rx_bit == 4'd9) begin
                    rx_busy <= 1'b0;
                    rx_byte_valid_o <= rx_sync[1];
                end else begin
                    rx_shift <= {rx_sync[1], rx_shift[7:1]};
                end
            end
        end
    end

    // shifter idles at all ones so the line rests high
    assign tx_o = tx_shift[0];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            tx_shift <= '1;
            tx_busy_o <= 1'b0;
            tx_tick <= '0;
            tx_bit <= '0;
        end else if (!tx_busy_o) begin
            if (tx_byte_valid_i) begin
                tx_shift <= {1'b1, tx_byte_i, 1'b0};
                tx_busy_o <= 1'b1;
                tx_tick <= '0;
                tx_bit <= '0;
            end
        end else if (en_16x) begin
            tx_tick <= tx_tick + 1'b1;
            if (tx_tick == 4'd15) begin
                tx_shift <= {1'b1, tx_shift[9:1]};
                tx_bit <= tx_bit + 1'b1;
                if (tx_bit == 4'd9)
                    tx_busy_o <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/bm_stream_if.sv
`timescale 1ns/1ps

// byte stream, a byte moves when valid and ready are both high
interface bm_stream_if;
    bm_line_pkg::byte_t data;
    logic valid;
    logic ready;
    logic last;
    logic err;

    modport source (output data, output valid, output last, output err, input ready);
    modport sink (input data, input valid, input last, input err, output ready);
endinterface

//--- hdl/bm_cmd_pkg.sv
package bm_cmd_pkg;

    localparam int ADDR_W = 24;

    // bit 23 selects write, bits 21..2 give the word address
    typedef logic [ADDR_W-1:0] cmd_addr_t;
    typedef logic [19:0] word_adr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0] strb_t;
    typedef logic [7:0] len_t;

    // a read returns length+1 bytes
    localparam int MAX_READ_LEN = 11;
    localparam int ENC_DEPTH = 16;
    // null bytes in a row that force a resync
    localparam int NULL_RUN = 4;

    typedef enum logic [3:0] {
        st_idle,
        st_addr2,
        st_addr1,
        st_addr0,
        st_read_len,
        st_echo2,
        st_echo1,
        st_echo0,
        st_read_bus,
        st_read_send,
        st_write_byte,
        st_write_bus,
        st_write_count,
        st_drain
    } cmd_state_t;

endpackage

//--- hdl/bm_line_pkg.sv
package bm_line_pkg;

    // system clock and serial line rate
    localparam longint CLK_HZ = 125_000_000;
    localparam longint BAUD = 3_906_250;

    // fractional baud accumulator
    localparam int ACC_BITS = 10;
    // rounded step for a 16x enable
    localparam int ACC_INC =
        int'((2 * (longint'(1) << ACC_BITS) * 16 * BAUD / CLK_HZ + 1) / 2);

    // one byte on the line or on a stream
    typedef logic [7:0] byte_t;

endpackage
